// ==== hw/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit import mipsPkg::*; (
  input  ctrlT                 ctrl,
  input  logic [dataWidth-1:0] ir,
  input  logic [dataWidth-1:0] rdData1,
  input  logic [dataWidth-1:0] rdData2,
  output logic [dataWidth-1:0] aluResult,
  output logic                 zero
);

  logic [dataWidth-1:0] immExt;
  logic [dataWidth-1:0] opA;
  logic [dataWidth-1:0] opB;

  // ============================================================
  // operands
  // ============================================================

  // 16-bit offset of lw, sw and beq
  assign immExt = {{16{ir[15]}}, ir[15:0]};

  assign opA = rdData1;
  assign opB = ctrl.aluSrc ? immExt : rdData2;

  // ============================================================
  // alu
  // ============================================================

  always_comb begin
    case (ctrl.aluOp)
      aluAdd: aluResult = opA + opB;
      aluSub: aluResult = opA - opB;
      aluAnd: aluResult = opA & opB;
      aluOr:  aluResult = opA | opB;
      // signed compare
      aluSlt: begin
        aluResult = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
      end
      // j and jal, nothing to compute
      default: aluResult = '0;
    endcase
  end

  // beq looks at this after the subtract
  assign zero = (aluResult == '0);

endmodule

// ==== hw/mainControl.sv ====
`timescale 1ns/1ps

module mainControl import mipsPkg::*; (
  input  logic                 rst,
  input  logic [dataWidth-1:0] ir,
  output ctrlT                 ctrl
);

  opcodeT opcode;
  functT  funct;
  ctrlT   decoded;

  // instruction fields seen as encodings
  assign opcode = opcodeT'(ir[31:26]);
  assign funct  = functT'(ir[5:0]);

  // ============================================================
  // decode
  // ============================================================

  always_comb begin
    // default is a no-op with nothing written
    decoded       = '0;
    decoded.aluOp = aluNone;
    case (opcode)
      opRtype: begin
        decoded.regDst   = 1'b1;
        decoded.regWrite = 1'b1;
        case (funct)
          fnAdd:   decoded.aluOp = aluAdd;
          fnSub:   decoded.aluOp = aluSub;
          fnAnd:   decoded.aluOp = aluAnd;
          fnOr:    decoded.aluOp = aluOr;
          fnSlt:   decoded.aluOp = aluSlt;
          // unsupported funct, drop the write
          default: decoded.regWrite = 1'b0;
        endcase
      end
      opLw: begin
        decoded.aluSrc   = 1'b1;
        decoded.memToReg = 1'b1;
        decoded.regWrite = 1'b1;
        decoded.aluOp    = aluAdd;
      end
      opSw: begin
        decoded.aluSrc   = 1'b1;
        decoded.memWrite = 1'b1;
        decoded.aluOp    = aluAdd;
      end
      opBeq: begin
        // equal operands leave a zero difference
        decoded.branch = 1'b1;
        decoded.aluOp  = aluSub;
      end
      opJ: begin
        decoded.jump = 1'b1;
      end
      opJal: begin
        decoded.jump     = 1'b1;
        decoded.link     = 1'b1;
        decoded.regWrite = 1'b1;
      end
      default: ;
    endcase
  end

  // strobes held off while in reset
  always_comb begin
    ctrl = decoded;
    if (!rst) begin
      ctrl.regWrite = 1'b0;
      ctrl.memWrite = 1'b0;
      ctrl.branch   = 1'b0;
      ctrl.jump     = 1'b0;
    end
  end

endmodule

// ==== hw/mipsPkg.sv ====
package mipsPkg;

  // ============================================================
  // sizing
  // ============================================================

  // machine word
  localparam int dataWidth = 32;
  // register index
  localparam int regAddrWidth = 5;
  // data memory word address, 128 words
  localparam int dmemAddrWidth = 7;
  // jal link destination
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

  // ============================================================
  // encodings
  // ============================================================

  // major opcodes, ir[31:26]
  typedef enum logic [5:0] {
    opRtype = 6'b000000,
    opJ     = 6'b000010,
    opJal   = 6'b000011,
    opBeq   = 6'b000100,
    opLw    = 6'b100011,
    opSw    = 6'b101011
  } opcodeT;

  // r-type function codes, ir[5:0]
  typedef enum logic [5:0] {
    fnAdd = 6'b100000,
    fnSub = 6'b100010,
    fnAnd = 6'b100100,
    fnOr  = 6'b100101,
    fnSlt = 6'b101010
  } functT;

  // alu operations
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluNone
  } aluOpT;

  // decoded controls for one instruction
  typedef struct packed {
    logic  regDst;    // 1 writes rd, 0 writes rt
    logic  aluSrc;    // 1 takes the immediate
    logic  memToReg;
    logic  regWrite;
    logic  memWrite;
    logic  branch;
    logic  jump;
    logic  link;      // jal, pc plus 4 into linkReg
    aluOpT aluOp;
  } ctrlT;

  // register file write as it really happened
  typedef struct packed {
    logic                    we;
    logic [regAddrWidth-1:0] addr;
    logic [dataWidth-1:0]    data;
  } wbT;

endpackage

// ==== hw/pcUnit.sv ====
`timescale 1ns/1ps

module pcUnit import mipsPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  ctrlT                 ctrl,
  input  logic [dataWidth-1:0] ir,
  input  logic                 zero,
  output logic [dataWidth-1:0] pc,
  output logic [dataWidth-1:0] pcPlus4
);

  logic [dataWidth-1:0] branchOffset;
  logic [dataWidth-1:0] branchTarget;
  logic [dataWidth-1:0] jumpTarget;
  logic [dataWidth-1:0] pcNext;

  assign pcPlus4 = pc + 32'd4;

  // sign-extended word offset, already in bytes
  assign branchOffset = {{14{ir[15]}}, ir[15:0], 2'b00};
  assign branchTarget = pcPlus4 + branchOffset;

  // region of pc plus 4 with the 26-bit index
  assign jumpTarget = {pcPlus4[31:28], ir[25:0], 2'b00};

  // jump wins, then a taken beq
  always_comb begin
    if (ctrl.jump) begin
      pcNext = jumpTarget;
    end else if (ctrl.branch && zero) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  ctrlT                 ctrl,
  input  logic [dataWidth-1:0] ir,
  input  logic [dataWidth-1:0] aluResult,
  input  logic [dataWidth-1:0] dmemRdata,
  input  logic [dataWidth-1:0] pcPlus4,
  output logic [dataWidth-1:0] rdData1,
  output logic [dataWidth-1:0] rdData2,
  output wbT                   wb
);

  logic [dataWidth-1:0]    regs [32];
  logic [regAddrWidth-1:0] rs;
  logic [regAddrWidth-1:0] rt;
  logic [regAddrWidth-1:0] rd;
  logic [regAddrWidth-1:0] wrAddr;
  logic [dataWidth-1:0]    wrData;
  logic                    wrEn;

  assign rs = ir[25:21];
  assign rt = ir[20:16];
  assign rd = ir[15:11];

  // ============================================================
  // read ports, register 0 is hardwired
  // ============================================================

  assign rdData1 = (rs == '0) ? '0 : regs[rs];
  assign rdData2 = (rt == '0) ? '0 : regs[rt];

  // ============================================================
  // write port
  // ============================================================

  // destination, link beats regDst
  assign wrAddr = ctrl.link ? linkReg : (ctrl.regDst ? rd : rt);

  // write data source
  assign wrData = ctrl.link     ? pcPlus4   :
                  ctrl.memToReg ? dmemRdata : aluResult;

  // no write ever lands on register 0
  assign wrEn = ctrl.regWrite && (wrAddr != '0);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // observation of the write performed this cycle
  assign wb = '{we: wrEn, addr: wrAddr, data: wrData};

endmodule

// ==== hw/singleCycleMips.sv ====
`timescale 1ns/1ps

module singleCycleMips import mipsPkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  // instruction fetch
  output logic [dataWidth-1:0]     irAddr,
  input  logic [dataWidth-1:0]     ir,
  // data memory
  output logic [dmemAddrWidth-1:0] dmemAddr,
  output logic [dataWidth-1:0]     dmemWdata,
  output logic                     dmemWe,
  input  logic [dataWidth-1:0]     dmemRdata,
  // write-back observation
  output wbT                       wb
);

  ctrlT                 ctrl;
  logic [dataWidth-1:0] pc;
  logic [dataWidth-1:0] pcPlus4;
  logic [dataWidth-1:0] rdData1;
  logic [dataWidth-1:0] rdData2;
  logic [dataWidth-1:0] aluResult;
  logic                 zero;

  // ============================================================
  // datapath
  // ============================================================

  mainControl u_mainControl (
    .rst  (rst),
    .ir   (ir),
    .ctrl (ctrl)
  );

  pcUnit u_pcUnit (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .ir      (ir),
    .zero    (zero),
    .pc      (pc),
    .pcPlus4 (pcPlus4)
  );

  regFile u_regFile (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .ir        (ir),
    .aluResult (aluResult),
    .dmemRdata (dmemRdata),
    .pcPlus4   (pcPlus4),
    .rdData1   (rdData1),
    .rdData2   (rdData2),
    .wb        (wb)
  );

  executeUnit u_executeUnit (
    .ctrl      (ctrl),
    .ir        (ir),
    .rdData1   (rdData1),
    .rdData2   (rdData2),
    .aluResult (aluResult),
    .zero      (zero)
  );

  // memory ports
  assign irAddr    = pc;
  // byte address to word index
  assign dmemAddr  = aluResult[dmemAddrWidth+1:2];
  assign dmemWdata = rdData2;
  assign dmemWe    = ctrl.memWrite;

endmodule

// ==== tb.f ====
hw/mipsPkg.sv
hw/mainControl.sv
hw/pcUnit.sv
hw/regFile.sv
hw/executeUnit.sv
hw/singleCycleMips.sv
test/mipsAsserts_asserts.sv
test/tbMips.sv

// ==== test/mipsAsserts_asserts.sv ====
`timescale 1ns/1ps

module mipsAsserts import mipsPkg::*; (
  input logic                 clk,
  input logic                 rst,
  input logic [dataWidth-1:0] irAddr,
  input logic                 dmemWe,
  input wbT                   wb
);

  // read by the testbench at the end of the run
  int failCount = 0;

  // fetch stays on word boundaries
  alignedFetch: assert property (@(posedge clk) irAddr[1:0] == 2'b00)
    else begin
      $error("irAddr %h is not word aligned", irAddr);
      failCount++;
    end

  // a load or r-type write never comes with a store
  exclusiveStrobes: assert property (@(posedge clk) disable iff (!rst) !(wb.we && dmemWe))
    else begin
      $error("register write and store strobe active together");
      failCount++;
    end

  // register 0 is never a real destination
  noZeroWrite: assert property (@(posedge clk) disable iff (!rst) wb.we |-> wb.addr != '0)
    else begin
      $error("register write reported for register 0");
      failCount++;
    end

  // quiet core while held in reset
  resetQuiet: assert property (@(posedge clk) !rst |-> irAddr == '0 && !dmemWe && !wb.we)
    else begin
      $error("fetch address or strobes active during reset");
      failCount++;
    end

endmodule

// ==== test/tbMips.sv ====
`timescale 1ns/1ps

module tbMips import mipsPkg::*; ();

  logic                     clk;
  logic                     rst;
  logic [dataWidth-1:0]     irAddr;
  logic [dataWidth-1:0]     ir;
  logic [dmemAddrWidth-1:0] dmemAddr;
  logic [dataWidth-1:0]     dmemWdata;
  logic                     dmemWe;
  logic [dataWidth-1:0]     dmemRdata;
  wbT                       wb;

  // expected effects of one instruction
  typedef struct packed {
    logic [31:0] nextPc;
    logic        memWe;
    logic [6:0]  memAddr;
    logic [31:0] memWdata;
    logic        wbWe;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic        halt;
  } expT;

  logic [31:0] imem [64];
  logic [31:0] dmem [128];
  logic [31:0] shadowRegs [32];
  logic [31:0] shadowMem [128];
  logic [31:0] shadowPc;
  logic [31:0] rngState;
  logic        checkEn;
  logic        halted;
  expT         want;
  int          errors;
  int          tests;
  int          failedTests;

  singleCycleMips u_singleCycleMips (
    .clk       (clk),
    .rst       (rst),
    .irAddr    (irAddr),
    .ir        (ir),
    .dmemAddr  (dmemAddr),
    .dmemWdata (dmemWdata),
    .dmemWe    (dmemWe),
    .dmemRdata (dmemRdata),
    .wb        (wb)
  );

  bind singleCycleMips mipsAsserts u_mipsAsserts (
    .clk    (clk),
    .rst    (rst),
    .irAddr (irAddr),
    .dmemWe (dmemWe),
    .wb     (wb)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ============================================================
  // memory models
  // ============================================================

  // both read combinationally, word indexed
  assign ir        = imem[irAddr[7:2]];
  assign dmemRdata = dmem[dmemAddr];

  // store commits on the edge that ends the cycle
  always @(posedge clk) begin
    if (dmemWe) begin
      dmem[dmemAddr] <= dmemWdata;
    end
  end

  // ============================================================
  // helpers
  // ============================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] encodeR(input functT fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
    return {opRtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encodeI(input opcodeT op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encodeJ(input opcodeT op, input logic [25:0] idx);
    return {op, idx};
  endfunction

  // 7 stands for the link register
  function automatic logic [4:0] pickReg(input logic [2:0] b);
    return (b == 3'd7) ? 5'd31 : {2'b00, b};
  endfunction

  function automatic functT pickFunct(input logic [2:0] b);
    case (b)
      3'd0, 3'd5: return fnAdd;
      3'd1, 3'd6: return fnSub;
      3'd2, 3'd7: return fnAnd;
      3'd3:       return fnOr;
      default:    return fnSlt;
    endcase
  endfunction

  // ============================================================
  // reference model
  // ============================================================

  function automatic expT refStep(input logic [31:0] pcNow, input logic [31:0] instr);
    expT         e;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] pc4;
    logic [31:0] addr;
    rs   = instr[25:21];
    rt   = instr[20:16];
    a    = shadowRegs[rs];
    b    = shadowRegs[rt];
    sext = {{16{instr[15]}}, instr[15:0]};
    pc4  = pcNow + 32'd4;
    addr = a + sext;
    e        = '0;
    e.nextPc = pc4;
    case (instr[31:26])
      6'h00: begin
        e.wbWe   = 1'b1;
        e.wbAddr = instr[15:11];
        case (instr[5:0])
          6'h20:   e.wbData = a + b;
          6'h22:   e.wbData = a - b;
          6'h24:   e.wbData = a & b;
          6'h25:   e.wbData = a | b;
          6'h2a:   e.wbData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: e.wbWe = 1'b0;
        endcase
      end
      // lw
      6'h23: begin
        e.wbWe   = 1'b1;
        e.wbAddr = rt;
        e.wbData = shadowMem[addr[8:2]];
      end
      // sw
      6'h2b: begin
        e.memWe    = 1'b1;
        e.memAddr  = addr[8:2];
        e.memWdata = b;
      end
      // beq, word offset from pc plus 4
      6'h04: begin
        if (a == b) begin
          e.nextPc = pc4 + {sext[29:0], 2'b00};
        end
      end
      6'h02: begin
        e.nextPc = {pc4[31:28], instr[25:0], 2'b00};
        e.halt   = (e.nextPc == pcNow);
      end
      6'h03: begin
        e.nextPc = {pc4[31:28], instr[25:0], 2'b00};
        e.wbWe   = 1'b1;
        e.wbAddr = 5'd31;
        e.wbData = pc4;
      end
      default: ;
    endcase
    // register 0 keeps its value
    if (e.wbAddr == 5'd0) begin
      e.wbWe = 1'b0;
    end
    return e;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expV,
                            input logic [31:0] actV);
    assert (actV === expV)
    else begin
      $display("Mismatch at %0t ns: %s expected %h, actual %h", $time, name, expV, actV);
      errors++;
    end
  endtask

  // ============================================================
  // checker, mid-cycle when the combinational path has settled
  // ============================================================

  always @(negedge clk) begin
    if (rst && checkEn) begin
      // model fetches from its own pc
      want = refStep(shadowPc, imem[shadowPc[7:2]]);
      checkValue("irAddr", shadowPc, irAddr);
      checkValue("dmemWe", want.memWe, dmemWe);
      if (want.memWe) begin
        checkValue("dmemAddr", want.memAddr, dmemAddr);
        checkValue("dmemWdata", want.memWdata, dmemWdata);
      end
      checkValue("wb.we", want.wbWe, wb.we);
      if (want.wbWe) begin
        checkValue("wb.addr", want.wbAddr, wb.addr);
        checkValue("wb.data", want.wbData, wb.data);
      end
      // step the shadow state past this instruction
      if (want.memWe) begin
        shadowMem[want.memAddr] = want.memWdata;
      end
      if (want.wbWe) begin
        shadowRegs[want.wbAddr] = want.wbData;
      end
      shadowPc = want.nextPc;
      if (want.halt) begin
        halted = 1'b1;
      end
    end
  end

  // ============================================================
  // programs
  // ============================================================

  // every unused word is a jump to itself, so each program ends in a halt
  task automatic clearMemories(input logic [31:0] salt);
    for (int i = 0; i < 64; i++) begin
      imem[i] = encodeJ(opJ, 26'(i));
    end
    for (int i = 0; i < 128; i++) begin
      dmem[i] = (32'h9E3779B1 * (i + 1)) ^ salt;
    end
  endtask

  task automatic loadResetProgram();
    clearMemories(32'h0);
    // store r1..r4 and the link register
    for (int k = 1; k <= 4; k++) begin
      imem[k-1] = encodeI(opSw, 5'(k), 5'd0, 16'(4 * k));
    end
    imem[4] = encodeI(opSw, 5'd31, 5'd0, 16'd20);
  endtask

  task automatic loadRtypeProgram();
    clearMemories(32'h0);
    dmem[0]  = 32'hFFFF_FFFB;
    dmem[1]  = 32'd7;
    imem[0]  = encodeI(opLw, 5'd1, 5'd0, 16'd0);
    imem[1]  = encodeI(opLw, 5'd2, 5'd0, 16'd4);
    imem[2]  = encodeR(fnAdd, 5'd3, 5'd1, 5'd2);
    imem[3]  = encodeR(fnSub, 5'd4, 5'd1, 5'd2);
    imem[4]  = encodeR(fnAnd, 5'd5, 5'd1, 5'd2);
    imem[5]  = encodeR(fnOr, 5'd6, 5'd1, 5'd2);
    // negative against positive, signed
    imem[6]  = encodeR(fnSlt, 5'd7, 5'd1, 5'd2);
    imem[7]  = encodeR(fnSlt, 5'd8, 5'd2, 5'd1);
    imem[8]  = encodeR(fnAdd, 5'd0, 5'd1, 5'd2);
    imem[9]  = encodeR(fnAdd, 5'd9, 5'd0, 5'd2);
    imem[10] = encodeI(opSw, 5'd0, 5'd0, 16'd8);
  endtask

  task automatic loadMemoryProgram();
    clearMemories(32'h0);
    dmem[2] = 32'd32;
    imem[0] = encodeI(opLw, 5'd1, 5'd0, 16'd0);
    imem[1] = encodeI(opSw, 5'd1, 5'd0, 16'd40);
    imem[2] = encodeI(opLw, 5'd2, 5'd0, 16'd40);
    imem[3] = encodeI(opLw, 5'd5, 5'd0, 16'd8);
    imem[4] = encodeI(opSw, 5'd2, 5'd5, 16'd4);
    // negative offset from a register base
    imem[5] = encodeI(opLw, 5'd6, 5'd5, 16'hFFFC);
    imem[6] = encodeI(opSw, 5'd6, 5'd5, 16'd0);
  endtask

  task automatic loadControlProgram();
    clearMemories(32'h0);
    dmem[0]  = 32'd7;
    dmem[1]  = 32'd7;
    dmem[2]  = 32'd9;
    imem[0]  = encodeI(opLw, 5'd1, 5'd0, 16'd0);
    imem[1]  = encodeI(opLw, 5'd2, 5'd0, 16'd4);
    imem[2]  = encodeI(opLw, 5'd3, 5'd0, 16'd8);
    imem[3]  = encodeI(opBeq, 5'd3, 5'd1, 16'd5);
    imem[4]  = encodeI(opBeq, 5'd2, 5'd1, 16'd2);
    imem[5]  = encodeR(fnAdd, 5'd4, 5'd1, 5'd1);
    imem[6]  = encodeJ(opJ, 26'd10);
    imem[7]  = encodeJ(opJal, 26'd9);
    imem[8]  = encodeR(fnAdd, 5'd5, 5'd1, 5'd1);
    imem[9]  = encodeJ(opJ, 26'd6);
    imem[10] = encodeJ(opJ, 26'd13);
    imem[11] = encodeI(opSw, 5'd31, 5'd0, 16'd12);
    imem[12] = encodeJ(opJ, 26'd14);
    // taken backward branch to word 11
    imem[13] = encodeI(opBeq, 5'd0, 5'd0, 16'hFFFD);
    imem[14] = encodeI(opSw, 5'd4, 5'd0, 16'd16);
  endtask

  task automatic loadRandomProgram();
    logic [31:0] r;
    logic [31:0] pick;
    logic [15:0] imm;
    int          t;
    rngState = xorshift32(rngState);
    clearMemories(rngState);
    for (int i = 0; i < 40; i++) begin
      rngState = xorshift32(rngState);
      r        = rngState;
      rngState = xorshift32(rngState);
      pick     = rngState;
      imm      = {{7{r[27]}}, r[27:21], 2'b00};
      // forward targets only, the halt sits at word 40
      t        = i + 1 + int'(pick % (40 - i));
      case (r % 10)
        0, 1, 2, 3, 4: begin
          imem[i] = encodeR(pickFunct(r[31:29]), pickReg(r[10:8]), pickReg(r[13:11]),
                            pickReg(r[16:14]));
        end
        5: imem[i] = encodeI(opLw, pickReg(r[10:8]), pickReg(r[13:11]), imm);
        6: imem[i] = encodeI(opSw, pickReg(r[10:8]), pickReg(r[13:11]), imm);
        7: imem[i] = encodeI(opBeq, pickReg(r[10:8]), pickReg(r[13:11]), 16'(t - i - 1));
        8: imem[i] = encodeJ(opJ, 26'(t));
        default: imem[i] = encodeJ(opJal, 26'(t));
      endcase
    end
  endtask

  // ============================================================
  // sequencing
  // ============================================================

  task automatic enterReset();
    @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
  endtask

  task automatic runTest(input string name);
    int startErrors;
    int cycles;
    startErrors = errors;
    for (int i = 0; i < 128; i++) begin
      shadowMem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) begin
      shadowRegs[i] = 32'd0;
    end
    shadowPc = 32'd0;
    halted   = 1'b0;
    repeat (10) @(posedge clk);
    rst     <= 1'b1;
    checkEn  = 1'b1;
    cycles   = 0;
    while (!halted && cycles < 500) begin
      @(posedge clk);
      cycles++;
    end
    checkEn = 1'b0;
    if (!halted) begin
      $display("test %s: program did not reach its halt within 500 cycles", name);
      errors++;
    end
    // data memory image against the model
    for (int i = 0; i < 128; i++) begin
      checkValue($sformatf("dmem[%0d]", i), shadowMem[i], dmem[i]);
    end
    tests++;
    if (errors == startErrors) begin
      $display("test %s: passed after %0d cycles", name, cycles);
    end else begin
      failedTests++;
      $display("test %s: failed with %0d errors", name, errors - startErrors);
    end
  endtask

  initial begin
    int assertFails;
    // edge lands after every process is waiting
    rst         <= 1'b0;
    checkEn     = 1'b0;
    halted      = 1'b0;
    shadowPc    = 32'd0;
    errors      = 0;
    tests       = 0;
    failedTests = 0;
    rngState    = 32'd83108;
    clearMemories(32'h0);

    enterReset();
    loadResetProgram();
    runTest("reset");
    enterReset();
    loadRtypeProgram();
    runTest("rtype");
    enterReset();
    loadMemoryProgram();
    runTest("memory");
    enterReset();
    loadControlProgram();
    runTest("control");
    for (int n = 0; n < 4; n++) begin
      enterReset();
      loadRandomProgram();
      runTest($sformatf("random%0d", n));
    end

    assertFails = u_singleCycleMips.u_mipsAsserts.failCount;
    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests, failedTests, errors, assertFails);
    if (errors == 0 && assertFails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
